/* design/instrPkg.sv */
package instrPkg;

  ////////////////////
  // Major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011; // lb lh lw lbu lhu
  localparam logic [6:0] opFence  = 7'b0001111; // fence, fence.i
  localparam logic [6:0] opOpImm  = 7'b0010011; // I-type ALU
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opStore  = 7'b0100011; // sb sh sw
  localparam logic [6:0] opAmo    = 7'b0101111; // lr, sc, AMOs
  localparam logic [6:0] opOp     = 7'b0110011; // R-type ALU and muldiv
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opSystem = 7'b1110011; // CSR and privileged

  ////////////////////
  // Function fields
  localparam logic [6:0] funct7Zero      = 7'b0000000; // Plain R-type, logical shifts
  localparam logic [6:0] funct7Alt       = 7'b0100000; // sub, sra, srai
  localparam logic [6:0] funct7MulDiv    = 7'b0000001; // M extension
  localparam logic [6:0] funct7SfenceVma = 7'b0001001;
  localparam logic [4:0] funct5Lr        = 5'b00010;
  localparam logic [4:0] funct5Sc        = 5'b00011;

  // Same 32 bits, base layout or AMO layout
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } base;
    struct packed {
      logic [4:0] funct5; // lr / sc / AMO op
      logic       aq;     // Acquire
      logic       rl;     // Release
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } atom;
  } instrWordT;

endpackage

/* design/ctrlPkg.sv */
package ctrlPkg;

  typedef logic [2:0] resultSrcT; // Writeback mux select
  typedef logic [2:0] immSrcT;    // Immediate format for extend unit
  typedef logic [1:0] memRwT;     // {read, write}
  typedef logic [1:0] atomicT;
  typedef logic [1:0] aluCtrlT;   // {subArith, aluOp}
  typedef logic [2:0] funct3T;

  ////////////////////
  // Writeback sources
  localparam resultSrcT resAlu = 3'b000;
  localparam resultSrcT resMem = 3'b001; // Load data
  localparam resultSrcT resCsr = 3'b010;
  localparam resultSrcT resMdu = 3'b011; // Multiply/divide unit
  localparam resultSrcT resSc  = 3'b100; // sc success code

  ////////////////////
  // Immediate formats
  localparam immSrcT immI    = 3'b000;
  localparam immSrcT immS    = 3'b001;
  localparam immSrcT immB    = 3'b010;
  localparam immSrcT immJ    = 3'b011;
  localparam immSrcT immU    = 3'b100;
  localparam immSrcT immNone = 3'b101; // Zero offset for sc and AMO

  // Memory access
  localparam memRwT memNone  = 2'b00;
  localparam memRwT memWrite = 2'b01;
  localparam memRwT memRead  = 2'b10;
  localparam memRwT memAmo   = 2'b11; // Read-modify-write

  // Atomic class
  localparam atomicT atomNone = 2'b00;
  localparam atomicT atomLrSc = 2'b01;
  localparam atomicT atomAmo  = 2'b10;

  ////////////////////
  // Bundle widths
  localparam int decodeTableW = 22; // Main decoder table row
  localparam int ctrlWidthE   = 26; // Execute register
  localparam int ctrlWidthM   = 19; // Memory register
  localparam int ctrlWidthW   = 5;  // Writeback register

endpackage

/* design/mainDecoder.sv */
module mainDecoder (
  input  instrPkg::instrWordT InstrD,            // Instruction in Decode
  output ctrlPkg::immSrcT     ImmSrcD,           // Immediate format
  output logic                IllegalBaseInstrD, // No legal decode
  output logic                JumpD,
  output logic                BranchD,
  output logic                RegWriteD,
  output ctrlPkg::resultSrcT  ResultSrcD,
  output ctrlPkg::memRwT      MemRWD,
  output ctrlPkg::aluCtrlT    ALUControlD,
  output logic                ALUSrcAD,          // PC as operand A
  output logic                ALUSrcBD,          // Immediate as operand B
  output logic                ALUResultSrcD,     // Pass immediate / link value
  output logic                CSRReadD,
  output logic                CSRWriteD,
  output logic                PrivilegedD,       // ecall, mret, sfence.vma ...
  output ctrlPkg::funct3T     Funct3D,
  output logic                MDUD,              // Multiply/divide
  output ctrlPkg::atomicT     AtomicD,
  output logic                InvalidateICacheD,
  output logic                FlushDCacheD,
  output logic                FenceD             // fence.i or sfence.vma
);
  import instrPkg::*;
  import ctrlPkg::*;

  logic [6:0]              op;         // Opcode field
  logic [2:0]              f3;         // funct3 field
  logic [6:0]              f7;         // funct7 field
  logic                    f7Zero;     // funct7 all zero
  logic                    f7Alt;      // sub/sra encoding
  logic                    iShift;     // Legal shift immediate
  logic                    iFunct;     // Legal op-imm
  logic                    rFunct;     // Legal base R-type
  logic                    mFunct;     // Legal muldiv
  logic [decodeTableW-1:0] controls;   // Selected table row
  logic                    aluOp;      // ALU uses funct3
  logic                    fenceX;     // MISC-MEM opcode
  logic                    fenceI;
  logic                    sfenceVma;
  logic                    csrZeroSrc; // rs1 / uimm is zero
  logic                    subArith;   // Subtract or arithmetic shift

  assign op = InstrD.base.opcode;
  assign f3 = InstrD.base.funct3;
  assign f7 = InstrD.base.funct7;

  ////////////////////
  // funct7 legality
  assign f7Zero = (f7 == funct7Zero);
  assign f7Alt  = (f7 == funct7Alt);
  assign iShift = (f3 == 3'b001 & f7Zero) | (f3 == 3'b101 & (f7Zero | f7Alt)); // slli srli srai
  assign iFunct = iShift | (f3 != 3'b001 & f3 != 3'b101); // Non-shifts take any immediate
  assign rFunct = ((f3 == 3'b000 | f3 == 3'b101) & f7Alt) | f7Zero;
  assign mFunct = (f7 == funct7MulDiv);

  ////////////////////
  // Main table
  // RegW ImmSrc SrcA SrcB MemRW ResSrc | Br AluOp Jmp AluRes CsrRd Priv FenceX Mdu | Atomic Ill
  always_comb begin
    controls = {{(decodeTableW-1){1'b0}}, 1'b1}; // Illegal unless a row matches
    case (op)
      opLoad:   controls = {1'b1, immI, 2'b01, memRead, resMem, 8'b0000_0000, atomNone, 1'b0};
      opFence:  controls = {1'b0, immI, 2'b00, memNone, resAlu, 8'b0000_0010, atomNone, 1'b0};
      opOpImm: begin
        if (iFunct) begin
          controls = {1'b1, immI, 2'b01, memNone, resAlu, 8'b0100_0000, atomNone, 1'b0};
        end
      end
      opAuipc:  controls = {1'b1, immU, 2'b11, memNone, resAlu, 8'b0000_0000, atomNone, 1'b0};
      opStore:  controls = {1'b0, immS, 2'b01, memWrite, resAlu, 8'b0000_0000, atomNone, 1'b0};
      opAmo: begin
        if (InstrD.atom.funct5 == funct5Lr) begin
          controls = {1'b1, immI, 2'b00, memRead, resMem, 8'b0000_0000, atomLrSc, 1'b0};
        end else if (InstrD.atom.funct5 == funct5Sc) begin
          controls = {1'b1, immNone, 2'b01, memWrite, resSc, 8'b0000_0000, atomLrSc, 1'b0};
        end else begin
          controls = {1'b1, immNone, 2'b01, memAmo, resMem, 8'b0000_0000, atomAmo, 1'b0};
        end
      end
      opOp: begin
        if (rFunct) begin
          controls = {1'b1, immI, 2'b00, memNone, resAlu, 8'b0100_0000, atomNone, 1'b0};
        end else if (mFunct) begin
          controls = {1'b1, immI, 2'b00, memNone, resMdu, 8'b0000_0001, atomNone, 1'b0};
        end
      end
      opLui:    controls = {1'b1, immU, 2'b01, memNone, resAlu, 8'b0001_0000, atomNone, 1'b0};
      opBranch: controls = {1'b0, immB, 2'b11, memNone, resAlu, 8'b1000_0000, atomNone, 1'b0};
      opJalr:   controls = {1'b1, immI, 2'b01, memNone, resAlu, 8'b0011_0000, atomNone, 1'b0};
      opJal:    controls = {1'b1, immJ, 2'b11, memNone, resAlu, 8'b0011_0000, atomNone, 1'b0};
      opSystem: begin
        if (f3 == 3'b000) begin // Privileged, decoded further downstream
          controls = {1'b0, immI, 2'b00, memNone, resAlu, 8'b0000_0100, atomNone, 1'b0};
        end else begin          // CSR access
          controls = {1'b1, immI, 2'b00, memNone, resCsr, 8'b0000_1000, atomNone, 1'b0};
        end
      end
      default: ; // Stays illegal
    endcase
  end

  assign IllegalBaseInstrD = controls[0];
  assign {RegWriteD, ImmSrcD, ALUSrcAD, ALUSrcBD, MemRWD, ResultSrcD, BranchD, aluOp, JumpD,
          ALUResultSrcD, CSRReadD, PrivilegedD, fenceX, MDUD, AtomicD} =
         controls[decodeTableW-1:1];
  assign Funct3D = IllegalBaseInstrD ? 3'b000 : f3; // Whole bundle quiet when illegal

  // CSR set/clear with zero source reads only
  assign csrZeroSrc = (InstrD.base.rs1 == 5'd0);
  assign CSRWriteD  = CSRReadD & ~(csrZeroSrc & f3[1]);

  ////////////////////
  // Fences
  assign fenceI            = fenceX & (f3 == 3'b001);
  assign sfenceVma         = PrivilegedD & (f7 == funct7SfenceVma);
  assign FenceD            = fenceI | sfenceVma;
  assign InvalidateICacheD = fenceI; // Refetch after self-modifying code
  assign FlushDCacheD      = fenceI; // Push dirty lines before refetch

  // ALU decode, op[5] separates sub from addi
  assign subArith = (f3 == 3'b000 & f7[5] & op[5]) | (f3 == 3'b101 & f7[5]) |
                    (f3 == 3'b010) | (f3 == 3'b011);
  assign ALUControlD = {aluOp & subArith, aluOp};

  // An illegal word never reaches the register file
  illegalNoWrite: assert final (!(IllegalBaseInstrD && RegWriteD));

endmodule

/* design/executeStageCtrl.sv */
module executeStageCtrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               StallD, FlushD,
  input  logic               StallE, FlushE,
  input  logic [1:0]         FlagsE,            // {eq, lt} from comparator
  input  logic               RegWriteD,
  input  ctrlPkg::resultSrcT ResultSrcD,
  input  ctrlPkg::memRwT     MemRWD,
  input  logic               JumpD, BranchD,
  input  ctrlPkg::aluCtrlT   ALUControlD,
  input  logic               ALUSrcAD, ALUSrcBD, ALUResultSrcD,
  input  logic               CSRReadD, CSRWriteD, PrivilegedD,
  input  ctrlPkg::funct3T    Funct3D,
  input  logic               MDUD,
  input  ctrlPkg::atomicT    AtomicD,
  input  logic               InvalidateICacheD, FlushDCacheD, FenceD,
  output logic               InstrValidD,
  output logic               PCSrcE,            // Redirect fetch
  output ctrlPkg::aluCtrlT   ALUControlE,
  output logic               ALUSrcAE, ALUSrcBE, ALUResultSrcE,
  output logic               MemReadE, CSRReadE,
  output ctrlPkg::funct3T    Funct3E,
  output logic               IntDivE, MDUE,
  output logic               JumpE, BranchE,
  output logic               SCE,
  output logic               BranchSignedE,
  output logic               StoreStallD,       // Hold D behind a store
  output logic               RegWriteE,
  output ctrlPkg::resultSrcT ResultSrcE,
  output ctrlPkg::memRwT     MemRWE,
  output logic               CSRWriteE, PrivilegedE,
  output ctrlPkg::atomicT    AtomicE,
  output logic               InvalidateICacheE, FlushDCacheE, FenceE,
  output logic               InstrValidE
);
  import ctrlPkg::*;

  logic [ctrlWidthE-1:0] ctrlE;        // Execute control register
  logic                  eqE, ltE;     // Comparator flags
  logic                  branchFlagE;  // eq or lt per funct3
  logic                  branchTakenE;

  ////////////////////
  // Decode valid bit
  always_ff @(posedge clk) begin
    if (reset || FlushD) begin
      InstrValidD <= 1'b0;
    end else if (!StallD) begin
      InstrValidD <= 1'b1;
    end
  end

  // Execute register, flush beats stall
  always_ff @(posedge clk) begin
    if (reset || FlushE) begin
      ctrlE <= '0;
    end else if (!StallE) begin
      ctrlE <= {RegWriteD, ResultSrcD, MemRWD, JumpD, BranchD, ALUControlD, ALUSrcAD,
                ALUSrcBD, ALUResultSrcD, CSRReadD, CSRWriteD, PrivilegedD, Funct3D, MDUD,
                AtomicD, InvalidateICacheD, FlushDCacheD, FenceD, InstrValidD};
    end
  end

  assign {RegWriteE, ResultSrcE, MemRWE, JumpE, BranchE, ALUControlE, ALUSrcAE, ALUSrcBE,
          ALUResultSrcE, CSRReadE, CSRWriteE, PrivilegedE, Funct3E, MDUE, AtomicE,
          InvalidateICacheE, FlushDCacheE, FenceE, InstrValidE} = ctrlE;

  ////////////////////
  // Branch resolution
  assign {eqE, ltE}    = FlagsE;
  assign branchFlagE   = Funct3E[2] ? ltE : eqE;       // blt/bge family uses lt
  assign branchTakenE  = branchFlagE ^ Funct3E[0];     // Odd funct3 inverts
  assign PCSrcE        = JumpE | (BranchE & branchTakenE);
  assign BranchSignedE = ~(Funct3E[2:1] == 2'b11);     // bltu, bgeu unsigned

  assign MemReadE = MemRWE[1];
  assign SCE      = (ResultSrcE == resSc);
  assign IntDivE  = MDUE & Funct3E[2];                 // div, divu, rem, remu

  // Cache cannot accept an access right behind a write
  assign StoreStallD = MemRWE[0] & (MemRWD[1] | MemRWD[0] | (AtomicD != atomNone));

  // Redirects come only from a live instruction
  pcSrcValid: assert property (@(posedge clk) disable iff (reset) PCSrcE |-> InstrValidE);

endmodule

/* design/memWbStageCtrl.sv */
module memWbStageCtrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               StallM, FlushM,
  input  logic               StallW, FlushW,
  input  logic               RegWriteE,
  input  ctrlPkg::resultSrcT ResultSrcE,
  input  ctrlPkg::memRwT     MemRWE,
  input  logic               CSRReadE, CSRWriteE, PrivilegedE,
  input  ctrlPkg::funct3T    Funct3E,
  input  ctrlPkg::atomicT    AtomicE,
  input  logic               InvalidateICacheE, FlushDCacheE, FenceE,
  input  logic               InstrValidE, IntDivE,
  output ctrlPkg::memRwT     MemRWM,
  output logic               CSRReadM, CSRWriteM, PrivilegedM,
  output ctrlPkg::atomicT    AtomicM,
  output ctrlPkg::funct3T    Funct3M,
  output logic               RegWriteM,
  output logic               InvalidateICacheM, FlushDCacheM,
  output logic               InstrValidM, FenceM,
  output logic               CSRWriteFenceM,  // Flush younger stages
  output logic               RegWriteW, IntDivW,
  output ctrlPkg::resultSrcT ResultSrcW
);
  import ctrlPkg::*;

  logic [ctrlWidthM-1:0] ctrlM;       // Memory control register
  logic [ctrlWidthW-1:0] ctrlW;       // Writeback control register
  resultSrcT             ResultSrcM;
  logic                  IntDivM;

  ////////////////////
  // Memory stage
  always_ff @(posedge clk) begin
    if (reset || FlushM) begin
      ctrlM <= '0;
    end else if (!StallM) begin
      ctrlM <= {RegWriteE, ResultSrcE, MemRWE, CSRReadE, CSRWriteE, PrivilegedE, Funct3E,
                AtomicE, InvalidateICacheE, FlushDCacheE, FenceE, InstrValidE, IntDivE};
    end
  end

  assign {RegWriteM, ResultSrcM, MemRWM, CSRReadM, CSRWriteM, PrivilegedM, Funct3M, AtomicM,
          InvalidateICacheM, FlushDCacheM, FenceM, InstrValidM, IntDivM} = ctrlM;

  assign CSRWriteFenceM = CSRWriteM | FenceM; // CSR side effects or fence reach fetch

  ////////////////////
  // Writeback stage
  always_ff @(posedge clk) begin
    if (reset || FlushW) begin
      ctrlW <= '0;
    end else if (!StallW) begin
      ctrlW <= {RegWriteM, ResultSrcM, IntDivM};
    end
  end

  assign {RegWriteW, ResultSrcW, IntDivW} = ctrlW;

  // Read plus write in one access belongs to AMOs alone
  amoAccess: assert property (@(posedge clk) disable iff (reset)
                              (MemRWM == memAmo) |-> (AtomicM == atomAmo));

endmodule

/* design/controller.sv */
module controller (
  input  logic                clk,
  input  logic                reset,
  // Decode
  input  logic                StallD, FlushD,
  input  instrPkg::instrWordT InstrD,
  output ctrlPkg::immSrcT     ImmSrcD,
  output logic                IllegalBaseInstrD, JumpD, BranchD,
  output logic                InstrValidD,
  output logic                StoreStallD,
  // Execute
  input  logic                StallE, FlushE,
  input  logic [1:0]          FlagsE,         // {eq, lt}
  output logic                PCSrcE,
  output ctrlPkg::aluCtrlT    ALUControlE,
  output logic                ALUSrcAE, ALUSrcBE, ALUResultSrcE,
  output logic                MemReadE, CSRReadE,
  output ctrlPkg::funct3T     Funct3E,
  output logic                IntDivE, MDUE, JumpE, BranchE, SCE, BranchSignedE,
  output logic                InstrValidE,
  // Memory
  input  logic                StallM, FlushM,
  output ctrlPkg::memRwT      MemRWM,
  output logic                CSRReadM, CSRWriteM, PrivilegedM,
  output ctrlPkg::atomicT     AtomicM,
  output ctrlPkg::funct3T     Funct3M,
  output logic                RegWriteM, InvalidateICacheM, FlushDCacheM,
  output logic                InstrValidM, FenceM, CSRWriteFenceM,
  // Writeback
  input  logic                StallW, FlushW,
  output logic                RegWriteW, IntDivW,
  output ctrlPkg::resultSrcT  ResultSrcW
);
  import ctrlPkg::*;

  // Decode bundle
  logic      RegWriteD;
  resultSrcT ResultSrcD;
  memRwT     MemRWD;
  aluCtrlT   ALUControlD;
  logic      ALUSrcAD, ALUSrcBD, ALUResultSrcD;
  logic      CSRReadD, CSRWriteD, PrivilegedD;
  funct3T    Funct3D;
  logic      MDUD;
  atomicT    AtomicD;
  logic      InvalidateICacheD, FlushDCacheD, FenceD;

  // Execute bundle headed for Memory
  logic      RegWriteE;
  resultSrcT ResultSrcE;
  memRwT     MemRWE;
  logic      CSRWriteE, PrivilegedE;
  atomicT    AtomicE;
  logic      InvalidateICacheE, FlushDCacheE, FenceE;

  mainDecoder      decoder  (.*); // Combinational D-stage control
  executeStageCtrl execCtrl (.*); // D valid, E register, branch resolution
  memWbStageCtrl   memWbCtrl (.*); // M and W registers

endmodule

/* sim/controllerTb.sv */
module controllerTb;

  localparam int          clkPeriod    = 10;
  localparam int          driveDelay   = 1;             // Inputs change after the edge
  localparam int          resetCycles  = 8;
  localparam int          validTimeout = 4;             // Cycles for decode valid after reset
  localparam logic [31:0] nopInstr     = 32'h0000_0013; // addi x0, x0, 0

  logic        clk, reset;
  logic        StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW;
  logic [31:0] InstrD;
  logic [1:0]  FlagsE;                                  // {eq, lt}
  logic [2:0]  ImmSrcD, Funct3E, Funct3M, ResultSrcW;
  logic        IllegalBaseInstrD, JumpD, BranchD, InstrValidD, StoreStallD;
  logic        PCSrcE, ALUSrcAE, ALUSrcBE, ALUResultSrcE, MemReadE, CSRReadE;
  logic        IntDivE, MDUE, JumpE, BranchE, SCE, BranchSignedE, InstrValidE;
  logic [1:0]  ALUControlE, MemRWM, AtomicM;
  logic        CSRReadM, CSRWriteM, PrivilegedM, RegWriteM, InvalidateICacheM, FlushDCacheM;
  logic        InstrValidM, FenceM, CSRWriteFenceM, RegWriteW, IntDivW;

  // Output groups, same bit order as the case file columns
  logic [5:0] decodeVec;
  logic [9:0] execVec;
  logic [5:0] memVec;
  logic [4:0] wbVec;

  int    errorCount, testCount, failCount;
  bit    testFailed;
  string testName;

  controller dut (.*);

  assign decodeVec = {ImmSrcD, JumpD, BranchD, IllegalBaseInstrD};
  assign execVec   = {ALUControlE, ALUSrcAE, ALUSrcBE, SCE, IntDivE, MemReadE, PCSrcE,
                      BranchSignedE, InstrValidE};
  assign memVec    = {MemRWM, AtomicM, CSRWriteFenceM, InstrValidM};
  assign wbVec     = {ResultSrcW, RegWriteW, IntDivW};

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  task automatic settle();
    #driveDelay; // Combinational outputs follow the new inputs
  endtask

  task automatic stepCycles(input int n);
    int  seen;
    bit  late;
    time deadline;
    seen     = 0;
    late     = 1'b0;
    deadline = $time + 64'(n * clkPeriod + clkPeriod);
    while (seen < n && !late) begin
      @(posedge clk);
      #driveDelay;
      seen++;
      late = ($time > deadline); // Clock slower than expected
    end
    if (late) begin
      $display("Timeout while waiting for %0d clock cycles in test %s", n, testName);
      $display("Done: errors found");
      $finish;
    end
  endtask

  task automatic checkValue(input string what, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("Error %s: %s expected 0x%0h actual 0x%0h", testName, what, expected, actual);
      errorCount++;
      testFailed = 1'b1;
    end
  endtask

  task automatic reportTest();
    testCount++;
    if (testFailed) begin
      failCount++;
      $display("FAIL %s", testName);
    end else begin
      $display("ok   %s", testName);
    end
  endtask

  ////////////////////
  // One case line
  task automatic runCase(input string mode, input logic [31:0] instr, nextInstr,
                         input logic [1:0] flags, input logic [15:0] expD, expE, expM, expW);
    logic [2:0] funct3Exp;
    logic       csrExp;
    logic       privExp;
    logic       fenceIExp;
    logic       fenceExp;
    funct3Exp = expD[0] ? 3'b000 : instr[14:12];     // Illegal word carries a quiet bundle
    csrExp    = (expW[4:2] == 3'b010);               // CSR writeback source
    privExp   = (instr[6:0] == 7'b1110011) && (instr[14:12] == 3'b000);
    fenceIExp = (instr[6:0] == 7'b0001111) && (instr[14:12] == 3'b001);
    fenceExp  = fenceIExp | (privExp && (instr[31:25] == 7'b0001001)); // Plus sfence.vma
    InstrD = instr;
    FlagsE = flags;
    settle();
    case (mode)
      "decode": begin
        checkValue("decode", expD, {10'b0, decodeVec});
      end
      "pipe": begin
        checkValue("decode", expD, {10'b0, decodeVec});
        stepCycles(1);
        InstrD = nextInstr;                          // Flags stay for the E cycle
        settle();
        checkValue("execute", expE, {6'b0, execVec});
        checkValue("execute side",
                   {8'b0, expD[2], expD[1], funct3Exp, expW[4:2] == 3'b011, csrExp,
                    expD[2] | (instr[6:0] == 7'b0110111)},
                   {8'b0, JumpE, BranchE, Funct3E, MDUE, CSRReadE, ALUResultSrcE});
        stepCycles(1);
        settle();
        checkValue("memory", expM, {10'b0, memVec});
        checkValue("memory side",
                   {6'b0, expW[1], csrExp, expM[1] & ~fenceExp, privExp, funct3Exp,
                    fenceIExp, fenceIExp, fenceExp},
                   {6'b0, RegWriteM, CSRReadM, CSRWriteM, PrivilegedM, Funct3M,
                    InvalidateICacheM, FlushDCacheM, FenceM});
        stepCycles(1);
        settle();
        checkValue("writeback", expW, {11'b0, wbVec});
      end
      "stall": begin
        stepCycles(1);
        InstrD = nextInstr;
        StallE = 1'b1;                               // Next word must not load
        stepCycles(1);
        StallE = 1'b0;
        settle();
        checkValue("held execute", expE, {6'b0, execVec});
      end
      "flush": begin
        stepCycles(1);
        InstrD = nextInstr;
        FlushE = 1'b1;
        stepCycles(1);
        FlushE = 1'b0;
        settle();
        checkValue("flushed execute", expE, {6'b0, execVec});
        stepCycles(1);
        settle();
        checkValue("flushed memory", expM, {10'b0, memVec}); // Bubble moves on
      end
      "hazard": begin
        stepCycles(1);
        InstrD = nextInstr;                          // Older word now in E
        settle();
        checkValue("StoreStallD", expE, {15'b0, StoreStallD});
      end
      default: begin
        $display("Unknown mode %s in test %s", mode, testName);
        errorCount++;
        testFailed = 1'b1;
      end
    endcase
    stepCycles(1); // Back to the drive point
  endtask

  ////////////////////
  // Main sequence
  initial begin
    int          fd;
    int          fields;
    int          guard;
    string       line, name, mode;
    logic [31:0] instr, nextInstr;
    logic [1:0]  flags;
    logic [15:0] expD, expE, expM, expW;
    errorCount = 0;
    testCount  = 0;
    failCount  = 0;
    testFailed = 1'b0;
    testName   = "resetState";
    reset      = 1'b1;
    {StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW} = '0;
    InstrD     = nopInstr;
    FlagsE     = 2'b00;
    stepCycles(resetCycles);
    checkValue("reset outputs", 16'h0000, {8'b0, PCSrcE, MemReadE, RegWriteM, RegWriteW,
               CSRWriteFenceM, InstrValidD, InstrValidE, InstrValidM});
    reportTest();
    reset = 1'b0;
    guard = 0;
    while (!InstrValidD && guard < validTimeout) begin
      stepCycles(1);
      guard++;
    end
    if (!InstrValidD) begin
      $display("Timeout: decode valid bit never rose after reset");
      errorCount++;
    end
    fd = $fopen("sim/controllerCases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file sim/controllerCases.txt");
      errorCount++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
          fields = $sscanf(line, "%s %s %h %h %b %h %h %h %h", name, mode, instr,
                           nextInstr, flags, expD, expE, expM, expW);
          if (fields == 9) begin
            testName   = name;
            testFailed = 1'b0;
            runCase(mode, instr, nextInstr, flags, expD, expE, expM, expW);
            reportTest();
          end else if (fields > 0) begin
            $display("Malformed case line: %s", line);
            errorCount++;
          end
        end
      end
      $fclose(fd);
    end
    $display("Tests: %0d run, %0d failed, %0d check errors", testCount, failCount, errorCount);
    if (errorCount == 0 && failCount == 0 && testCount > 1) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* sim/controllerCases.txt */
# name mode instr next flags(bin {eq,lt}) expD expE expM expW, all expected values in hex
# expD {ImmSrc,Jump,Branch,Illegal} expE {ALUCtrl,SrcA,SrcB,SC,IntDiv,MemRead,PCSrc,BrSigned,Valid}
# expM {MemRW,Atomic,CSRWriteFence,Valid} expW {ResultSrc,RegWrite,IntDiv}; hazard expE is StoreStallD
pipeLoad      pipe   00812283 00000013 00 00 04B 21 06
pipeStore     pipe   00612623 00000013 00 08 043 11 00
pipeAddi      pipe   00500093 00000013 00 00 143 01 02
pipeSrai      pipe   40225193 00000013 00 00 343 01 02
pipeSub       pipe   402081B3 00000013 00 00 303 01 02
pipeMul       pipe   022081B3 00000013 00 00 003 01 0E
pipeDiv       pipe   0220C1B3 00000013 00 00 013 01 0F
pipeLui       pipe   123452B7 00000013 00 20 043 01 02
pipeAuipc     pipe   00001297 00000013 00 20 0C3 01 02
pipeBeqTaken  pipe   00208463 00000013 10 12 0C7 01 00
pipeBneNot    pipe   00209463 00000013 10 12 0C3 01 00
pipeBltTaken  pipe   0020C463 00000013 01 12 0C7 01 00
pipeBltuTaken pipe   0020E463 00000013 01 12 0C5 01 00
pipeBgeuNot   pipe   0020F463 00000013 01 12 0C1 01 00
pipeJal       pipe   010000EF 00000013 00 1C 0C7 01 02
pipeJalr      pipe   000280E7 00000013 00 04 047 01 02
pipeLr        pipe   1001252F 00000013 00 00 00B 25 06
pipeSc        pipe   1861252F 00000013 00 28 063 15 12
pipeAmo       pipe   0061252F 00000013 00 28 04B 39 06
pipeCsrrw     pipe   340312F3 00000013 00 00 003 03 0A
pipeCsrrsZero pipe   300022F3 00000013 00 00 003 01 0A
pipeFenceI    pipe   0000100F 00000013 00 00 003 03 00
pipeIllegalOp pipe   0000007F 00000013 00 01 003 01 00
decSlliBadF7  decode 40109093 00000013 00 01 000 00 00
decAddBadF7   decode 042081B3 00000013 00 01 000 00 00
stallAdd      stall  002081B3 00812283 00 00 103 00 00
flushJal      flush  010000EF 00000013 00 00 002 00 00
flushStore    flush  00612623 00000013 00 00 002 00 00
hazStoreLoad  hazard 00612623 00812283 00 00 001 00 00
hazStoreStore hazard 00612623 00612623 00 00 001 00 00
hazStoreAmo   hazard 00612623 0061252F 00 00 001 00 00
hazStoreAdd   hazard 00612623 002081B3 00 00 000 00 00
hazLoadLoad   hazard 00812283 00812283 00 00 000 00 00

/* sim.f */
design/instrPkg.sv
design/ctrlPkg.sv
design/mainDecoder.sv
design/executeStageCtrl.sv
design/memWbStageCtrl.sv
design/controller.sv
sim/controllerTb.sv

/* Makefile */
SOURCES = design/instrPkg.sv design/ctrlPkg.sv design/mainDecoder.sv \
          design/executeStageCtrl.sv design/memWbStageCtrl.sv design/controller.sv \
          sim/controllerTb.sv

.PHONY: run clean

run: obj_dir/VcontrollerTb
	obj_dir/VcontrollerTb | tee sim.log
	grep -q "^Done: no errors$$" sim.log

obj_dir/VcontrollerTb: $(SOURCES) sim.f
	verilator --binary --timing --assert -f sim.f --top-module controllerTb -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log
